// File: vec_pkg.sv
// shared widths, opcodes, instruction fields and bus/lane structs for the vector unit
package vec_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////
    localparam int xlen       = 32;
    localparam int reg_idx_w  = 3;
    localparam int max_lanes  = 8;
    localparam int lane_idx_w = $clog2(max_lanes);
    localparam int op_w       = 4;

    //////////////////////////////////////////////////////////////////////
    // instruction word layout
    //////////////////////////////////////////////////////////////////////
    localparam int op_lo   = 28;
    localparam int mask_lo = 20;
    localparam int rd_lo   = 17;
    localparam int rs_lo   = 14;
    localparam int rt_lo   = 11;
    localparam int imm_lo  = 0;
    localparam int imm_w   = 11;

    // codes not listed here execute as nop
    typedef enum logic [op_w-1:0] {
        op_nop = 4'h0,
        op_ldi = 4'h1,
        op_add = 4'h2,
        op_sub = 4'h3,
        op_and = 4'h4,
        op_or  = 4'h5,
        op_xor = 4'h6,
        op_sll = 4'h7,
        op_srl = 4'h8
    } alu_op_t;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // lane traffic
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                 valid;
        alu_op_t              op;
        logic                 en;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        logic [xlen-1:0]      imm;
    } lane_op_t;

    typedef struct packed {
        logic                 we;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } lane_result_t;

endpackage

// File: vec_issue.sv
// wishbone slave front end: decodes instructions, forwards lane results and dispatches to lanes
`timescale 1ns/1ps

module vec_issue #(
    parameter int num_lanes = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  vec_pkg::wb_req_t                              wb_req,
    output vec_pkg::wb_rsp_t                              wb_rsp,
    output vec_pkg::lane_op_t     [num_lanes-1:0]         lane_ops,
    input  vec_pkg::lane_result_t [num_lanes-1:0]         lane_res,
    output logic [vec_pkg::reg_idx_w-1:0]                 rs_idx,
    output logic [vec_pkg::reg_idx_w-1:0]                 rt_idx,
    input  logic [num_lanes-1:0][vec_pkg::xlen-1:0]       rs_data,
    input  logic [num_lanes-1:0][vec_pkg::xlen-1:0]       rt_data,
    output logic [vec_pkg::reg_idx_w-1:0]                 bus_reg,
    output logic [$clog2(num_lanes)-1:0]                  bus_lane,
    input  logic [vec_pkg::xlen-1:0]                      bus_rdata
);

    localparam int lane_w = $clog2(num_lanes);

    logic [31:0]                          instr;
    vec_pkg::alu_op_t                     op;
    logic [vec_pkg::max_lanes-1:0]        mask;
    logic [vec_pkg::reg_idx_w-1:0]        rd;
    logic [vec_pkg::xlen-1:0]             imm;
    logic                                 req;
    logic                                 idle;
    logic                                 accept_w;
    logic                                 ack_set;
    logic                                 ack_q;
    logic [vec_pkg::xlen-1:0]             dat_q;
    logic                                 disp_valid;
    logic [num_lanes-1:0]                 res_busy;
    vec_pkg::lane_op_t [num_lanes-1:0]    disp_d;
    vec_pkg::lane_op_t [num_lanes-1:0]    disp_q;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////
    assign instr  = wb_req.dat_w;
    assign op     = vec_pkg::alu_op_t'(instr[vec_pkg::op_lo +: vec_pkg::op_w]);
    assign mask   = instr[vec_pkg::mask_lo +: vec_pkg::max_lanes];
    assign rd     = instr[vec_pkg::rd_lo +: vec_pkg::reg_idx_w];
    assign rs_idx = instr[vec_pkg::rs_lo +: vec_pkg::reg_idx_w];
    assign rt_idx = instr[vec_pkg::rt_lo +: vec_pkg::reg_idx_w];
    assign imm    = {{(vec_pkg::xlen - vec_pkg::imm_w){instr[vec_pkg::imm_lo + vec_pkg::imm_w - 1]}},
                     instr[vec_pkg::imm_lo +: vec_pkg::imm_w]};

    // word address is reg * num_lanes + lane
    assign bus_lane = wb_req.adr[lane_w-1:0];
    assign bus_reg  = wb_req.adr[lane_w +: vec_pkg::reg_idx_w];

    // operands, with the lane's own registered result taking priority
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            res_busy[i]   = lane_res[i].we;
            disp_d[i].valid = 1'b1;
            disp_d[i].op  = op;
            disp_d[i].en  = mask[i];
            disp_d[i].rd  = rd;
            disp_d[i].imm = imm;
            disp_d[i].a   = (lane_res[i].we && lane_res[i].rd == rs_idx) ?
                            lane_res[i].data : rs_data[i];
            disp_d[i].b   = (lane_res[i].we && lane_res[i].rd == rt_idx) ?
                            lane_res[i].data : rt_data[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus handshake and dispatch register
    //////////////////////////////////////////////////////////////////////
    assign req      = wb_req.cyc && wb_req.stb && !ack_q;
    assign idle     = !disp_valid && !(|res_busy);
    assign accept_w = req && wb_req.we;
    // reads wait for the pipeline to drain
    assign ack_set  = req && (wb_req.we || idle);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack_q      <= 1'b0;
            disp_valid <= 1'b0;
        end else begin
            ack_q      <= ack_set;
            disp_valid <= accept_w;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_w) begin
            disp_q <= disp_d;
        end
        if (ack_set && !wb_req.we) begin
            dat_q <= bus_rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            lane_ops[i]       = disp_q[i];
            lane_ops[i].valid = disp_valid;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

    // master must still hold the request while ack is up
    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

endmodule

// File: vec_lane.sv
// one simd lane, executes the dispatched op and registers its masked result
`timescale 1ns/1ps

module vec_lane (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [vec_pkg::lane_idx_w-1:0]  lane_index,
    input  vec_pkg::lane_op_t               op_in,
    output vec_pkg::lane_result_t           result
);

    localparam int shamt_w = $clog2(vec_pkg::xlen);

    logic [vec_pkg::xlen-1:0]       lane_ext;
    logic [vec_pkg::xlen-1:0]       alu;
    logic                           writes;
    logic                           we_q;
    logic [vec_pkg::reg_idx_w-1:0]  rd_q;
    logic [vec_pkg::xlen-1:0]       data_q;

    assign lane_ext = {{(vec_pkg::xlen - vec_pkg::lane_idx_w){1'b0}}, lane_index};

    always_comb begin
        writes = 1'b1;
        case (op_in.op)
            vec_pkg::op_ldi: alu = op_in.imm + lane_ext;
            vec_pkg::op_add: alu = op_in.a + op_in.b;
            vec_pkg::op_sub: alu = op_in.a - op_in.b;
            vec_pkg::op_and: alu = op_in.a & op_in.b;
            vec_pkg::op_or:  alu = op_in.a | op_in.b;
            vec_pkg::op_xor: alu = op_in.a ^ op_in.b;
            vec_pkg::op_sll: alu = op_in.a << op_in.b[shamt_w-1:0];
            vec_pkg::op_srl: alu = op_in.a >> op_in.b[shamt_w-1:0];
            default: begin
                // nop and unused codes
                alu    = '0;
                writes = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            we_q <= 1'b0;
        end else begin
            we_q <= op_in.valid && op_in.en && writes;
        end
    end

    always_ff @(posedge clk) begin
        rd_q   <= op_in.rd;
        data_q <= alu;
    end

    assign result = '{we: we_q, rd: rd_q, data: data_q};

    we_after_valid: assert property (@(posedge clk) disable iff (!rstn)
        result.we |-> $past(op_in.valid));

endmodule

// File: vec_regfile.sv
// vector register file, one write port per lane plus operand and host read ports
`timescale 1ns/1ps

module vec_regfile #(
    parameter int num_lanes = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  vec_pkg::lane_result_t [num_lanes-1:0]         lane_res,
    input  logic [vec_pkg::reg_idx_w-1:0]                 rs_idx,
    input  logic [vec_pkg::reg_idx_w-1:0]                 rt_idx,
    output logic [num_lanes-1:0][vec_pkg::xlen-1:0]       rs_data,
    output logic [num_lanes-1:0][vec_pkg::xlen-1:0]       rt_data,
    input  logic [vec_pkg::reg_idx_w-1:0]                 bus_reg,
    input  logic [$clog2(num_lanes)-1:0]                  bus_lane,
    output logic [vec_pkg::xlen-1:0]                      bus_rdata
);

    localparam int num_regs = 2 ** vec_pkg::reg_idx_w;

    logic [num_lanes-1:0][vec_pkg::xlen-1:0] vregs [num_regs];

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////
    // each lane owns its own element column
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int r = 0; r < num_regs; r++) begin
                vregs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < num_lanes; l++) begin
                if (lane_res[l].we) begin
                    vregs[lane_res[l].rd][l] <= lane_res[l].data;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////
    assign rs_data   = vregs[rs_idx];
    assign rt_data   = vregs[rt_idx];
    assign bus_rdata = vregs[bus_reg][bus_lane];

    bus_lane_range: assert property (@(posedge clk) disable iff (!rstn)
        bus_lane < num_lanes);

endmodule

// File: vec_unit.sv
// top level of the vector unit, issue stage feeding a row of lanes and the register file
`timescale 1ns/1ps

module vec_unit #(
    parameter int num_lanes = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  vec_pkg::wb_req_t  wb_req,
    output vec_pkg::wb_rsp_t  wb_rsp
);

    vec_pkg::lane_op_t     [num_lanes-1:0]        lane_ops;
    vec_pkg::lane_result_t [num_lanes-1:0]        lane_res;
    logic [vec_pkg::reg_idx_w-1:0]                rs_idx;
    logic [vec_pkg::reg_idx_w-1:0]                rt_idx;
    logic [num_lanes-1:0][vec_pkg::xlen-1:0]      rs_data;
    logic [num_lanes-1:0][vec_pkg::xlen-1:0]      rt_data;
    logic [vec_pkg::reg_idx_w-1:0]                bus_reg;
    logic [$clog2(num_lanes)-1:0]                 bus_lane;
    logic [vec_pkg::xlen-1:0]                     bus_rdata;

    vec_issue #(.num_lanes(num_lanes)) u_issue (
        .clk       (clk),
        .rstn      (rstn),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .lane_ops  (lane_ops),
        .lane_res  (lane_res),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .bus_reg   (bus_reg),
        .bus_lane  (bus_lane),
        .bus_rdata (bus_rdata)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        localparam logic [vec_pkg::lane_idx_w-1:0] idx = i;

        vec_lane u_lane (
            .clk        (clk),
            .rstn       (rstn),
            .lane_index (idx),
            .op_in      (lane_ops[i]),
            .result     (lane_res[i])
        );
    end

    vec_regfile #(.num_lanes(num_lanes)) u_regfile (
        .clk       (clk),
        .rstn      (rstn),
        .lane_res  (lane_res),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .bus_reg   (bus_reg),
        .bus_lane  (bus_lane),
        .bus_rdata (bus_rdata)
    );

endmodule

// File: tb_vec_unit.sv
// directed testbench for the vector unit, checks host reads against a register file model
`timescale 1ns/1ps

module tb_vec_unit;

    localparam int num_lanes  = 4;
    localparam int num_regs   = 8;
    localparam int clk_period = 100;
    localparam int drive_dly  = 1;
    localparam int ack_limit  = 16;
    // transfers over all tests, at worst 3 cycles per write and 6 per read
    localparam int num_writes   = 64;
    localparam int num_reads    = 6 * num_regs * num_lanes;
    localparam int limit_cycles = 2 * (num_writes * 3 + num_reads * 6) + 100;

    logic             clk = 1'b0;
    logic             rstn;
    vec_pkg::wb_req_t wb_req;
    vec_pkg::wb_rsp_t wb_rsp;

    logic [31:0] model [num_regs][num_lanes];
    int          errors;
    int          checks;
    integer      seed;

    vec_unit DUT (
        .clk    (clk),
        .rstn   (rstn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] make_instr(input logic [3:0] op, input logic [7:0] mask,
                                               input int rd, input int rs, input int rt,
                                               input int imm);
        return {op, mask, rd[2:0], rs[2:0], rt[2:0], imm[10:0]};
    endfunction

    task automatic model_exec(input logic [31:0] instr);
        logic [3:0]  op;
        logic [7:0]  mask;
        int          rd;
        int          rs;
        int          rt;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        bit          writes;
        op   = instr[31:28];
        mask = instr[27:20];
        rd   = instr[19:17];
        rs   = instr[16:14];
        rt   = instr[13:11];
        imm  = {{21{instr[10]}}, instr[10:0]};
        for (int i = 0; i < num_lanes; i++) begin
            a      = model[rs][i];
            b      = model[rt][i];
            writes = 1'b1;
            case (op)
                vec_pkg::op_ldi: res = imm + 32'(i);
                vec_pkg::op_add: res = a + b;
                vec_pkg::op_sub: res = a - b;
                vec_pkg::op_and: res = a & b;
                vec_pkg::op_or:  res = a | b;
                vec_pkg::op_xor: res = a ^ b;
                vec_pkg::op_sll: res = a << b[4:0];
                vec_pkg::op_srl: res = a >> b[4:0];
                default: begin
                    res    = '0;
                    writes = 1'b0;
                end
            endcase
            if (writes && mask[i]) begin
                model[rd][i] = res;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus access
    //////////////////////////////////////////////////////////////////////
    // entered and left a short delay after a rising edge
    task automatic wait_ack(input string what);
        bit seen;
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < ack_limit) begin
            @(posedge clk);
            #drive_dly;
            seen = wb_rsp.ack;
            n++;
        end
        checks++;
        assert (seen) else begin
            $display("no ack from the DUT within %0d cycles on %s", ack_limit, what);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [31:0] instr);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = '0;
        wb_req.dat_w = instr;
        wait_ack("an instruction write");
        // stb stays up through the ack cycle
        @(posedge clk);
        #drive_dly;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_read(input int adr, output logic [31:0] data);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wait_ack("an element read");
        data = wb_rsp.dat_r;
        @(posedge clk);
        #drive_dly;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic issue_instr(input logic [31:0] instr);
        model_exec(instr);
        wb_write(instr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////
    task automatic check_elem(input string name, input int r, input int l);
        logic [31:0] got;
        wb_read(r * num_lanes + l, got);
        checks++;
        assert (got === model[r][l]) else begin
            $display("mismatch %s v%0d[%0d]: expected %h actual %h",
                     name, r, l, model[r][l], got);
            errors++;
        end
    endtask

    task automatic check_all(input string name);
        for (int r = 0; r < num_regs; r++) begin
            for (int l = 0; l < num_lanes; l++) begin
                check_elem(name, r, l);
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_state();
        int err_before;
        err_before = errors;
        repeat (4) begin
            @(posedge clk);
            #drive_dly;
            checks++;
            assert (wb_rsp.ack === 1'b0) else begin
                $display("mismatch reset ack: expected 0 actual %b", wb_rsp.ack);
                errors++;
            end
        end
        check_all("reset");
        finish_test("reset", err_before);
    endtask

    task automatic load_immediate();
        int err_before;
        err_before = errors;
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 0, 0, 0, 5));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 1, 0, 0, -1));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 2, 0, 0, -1024));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 3, 0, 0, 1023));
        check_all("load_immediate");
        finish_test("load_immediate", err_before);
    endtask

    // each instruction reads the one issued just before it
    task automatic forward_chain();
        int err_before;
        err_before = errors;
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 1, 0, 0, 10));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 2, 0, 0, -3));
        issue_instr(make_instr(vec_pkg::op_add, 8'hff, 3, 1, 2, 0));
        issue_instr(make_instr(vec_pkg::op_sub, 8'hff, 4, 3, 1, 0));
        issue_instr(make_instr(vec_pkg::op_xor, 8'hff, 5, 4, 3, 0));
        issue_instr(make_instr(vec_pkg::op_add, 8'hff, 3, 3, 5, 0));
        check_all("forward_chain");
        finish_test("forward_chain", err_before);
    endtask

    task automatic lane_masking();
        int err_before;
        err_before = errors;
        issue_instr(make_instr(vec_pkg::op_ldi, 8'h05, 6, 0, 0, 77));
        issue_instr(make_instr(vec_pkg::op_sub, 8'h0a, 6, 6, 1, 0));
        issue_instr(make_instr(4'hc, 8'hff, 6, 1, 2, 9));
        issue_instr(make_instr(vec_pkg::op_nop, 8'hff, 6, 1, 2, 9));
        issue_instr(make_instr(4'hf, 8'hff, 1, 3, 3, -7));
        check_all("lane_masking");
        finish_test("lane_masking", err_before);
    endtask

    // shift amounts 33..36 reduce to 1..4
    task automatic shift_and_logic();
        int err_before;
        err_before = errors;
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 6, 0, 0, 1023));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 7, 0, 0, 33));
        issue_instr(make_instr(vec_pkg::op_sll, 8'hff, 0, 6, 7, 0));
        issue_instr(make_instr(vec_pkg::op_srl, 8'hff, 1, 6, 7, 0));
        issue_instr(make_instr(vec_pkg::op_ldi, 8'hff, 2, 0, 0, -256));
        issue_instr(make_instr(vec_pkg::op_and, 8'hff, 3, 6, 2, 0));
        issue_instr(make_instr(vec_pkg::op_or, 8'hff, 4, 1, 2, 0));
        issue_instr(make_instr(vec_pkg::op_srl, 8'hff, 5, 2, 7, 0));
        check_all("shift_and_logic");
        finish_test("shift_and_logic", err_before);
    endtask

    task automatic random_stream();
        int          err_before;
        logic [31:0] word;
        logic [3:0]  op;
        err_before = errors;
        for (int n = 0; n < 40; n++) begin
            word = $random(seed);
            // code 9 stands for the unused opcodes
            op   = 4'($unsigned($random(seed)) % 10);
            issue_instr({op, word[27:0]});
        end
        check_all("random_stream");
        finish_test("random_stream", err_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed   = 85;
        errors = 0;
        checks = 0;
        rstn   = 1'b0;
        wb_req = '0;
        for (int r = 0; r < num_regs; r++) begin
            for (int l = 0; l < num_lanes; l++) begin
                model[r][l] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #drive_dly;
        rstn = 1'b1;
        reset_state();
        load_immediate();
        forward_chain();
        lane_masking();
        shift_and_logic();
        random_stream();
        $display("checks %0d, failures %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: project.f
vec_pkg.sv
vec_issue.sv
vec_lane.sv
vec_regfile.sv
vec_unit.sv
tb_vec_unit.sv

// File: Makefile
TOP = tb_vec_unit
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
